// ==== hw/dcache_cfg_pkg.sv ====
// Geometry of the direct-mapped data cache.
// Byte address is split as tag | index | word | byte, with 16 lines of
// two 64-bit words each. Addresses below CACHE_START_ADDR are uncacheable.
package dcache_cfg_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int unsigned ADDR_W         = 32;
    localparam int unsigned DATA_W         = 64;
    localparam int unsigned LINE_W         = 128;
    localparam int unsigned BEATS_PER_LINE = LINE_W / DATA_W;
    localparam int unsigned BE_W           = DATA_W / 8;
    // byte offset inside a line, top bit picks the word
    localparam int unsigned OFFSET_W       = 4;
    localparam int unsigned INDEX_W        = 4;
    localparam int unsigned TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

    // everything below this address bypasses the cache
    localparam logic [ADDR_W-1:0] CACHE_START_ADDR = 32'h4000_0000;

    // ----------------------------------------------------------
    // data and address-field types
    // ----------------------------------------------------------
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    // word inside a line, also the refill beat number
    typedef logic [0:0]         beat_idx_t;

endpackage

// ==== hw/dcache_ctrl_pkg.sv ====
// Controller encodings: FSM states and the opcode on the memory port.
// The memory port carries only these three commands.
package dcache_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        STORE_WRITE,
        REFILL_REQ,
        REFILL_DATA,
        BYPASS_REQ,
        BYPASS_DATA
    } ctrl_state_e;

    // memory command opcode
    typedef enum logic [1:0] {
        // whole line, two beats, word 0 first
        CMD_READ_LINE,
        // one beat
        CMD_READ_WORD,
        CMD_WRITE_WORD
    } mem_cmd_e;

endpackage

// ==== hw/array_port_if.sv ====
// Controller access to the tag/data store.
// Read is synchronous: rd_line and hit belong to the rd_index of the
// previous cycle; hit compares against the current lookup_tag.
`timescale 1ns/1ps

interface array_port_if import dcache_cfg_pkg::*; ();

    // read side
    logic      rd_en;
    index_t    rd_index;
    line_t     rd_line;
    logic      hit;

    // word write under byte enables
    logic      wr_en;
    index_t    wr_index;
    beat_idx_t wr_word;
    logic [BE_W-1:0] wr_be;
    word_t     wr_data;

    // tag write, marks the line at wr_index valid with lookup_tag
    logic      tag_wr_en;
    tag_t      lookup_tag;

    modport ctrl (
        output rd_en, rd_index, wr_en, wr_index, wr_word, wr_be, wr_data,
        output tag_wr_en, lookup_tag,
        input  rd_line, hit
    );

    modport array (
        input  rd_en, rd_index, wr_en, wr_index, wr_word, wr_be, wr_data,
        input  tag_wr_en, lookup_tag,
        output rd_line, hit
    );

endinterface

// ==== hw/refill_beat_counter.sv ====
// Tracks the beats of one line refill. Beats come in word order,
// so the count is also the word index of the arriving beat.
`timescale 1ns/1ps

module refill_beat_counter import dcache_cfg_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      start_i,
    input  logic      beat_valid_i,
    input  beat_idx_t want_word_i,
    output beat_idx_t beat_idx_o,
    output logic      is_wanted_o,
    output logic      last_o
);

    beat_idx_t beat_idx_q;
    // set between start and the final beat
    logic      armed_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_idx_q <= '0;
            armed_q    <= 1'b0;
        end else if (start_i) begin
            beat_idx_q <= '0;
            armed_q    <= 1'b1;
        end else if (beat_valid_i && armed_q) begin
            beat_idx_q <= beat_idx_q + 1'b1;
            if (last_o) armed_q <= 1'b0;
        end
    end

    assign beat_idx_o  = beat_idx_q;
    assign is_wanted_o = (beat_idx_q == want_word_i);
    assign last_o      = (beat_idx_q == beat_idx_t'(BEATS_PER_LINE - 1));

    // memory must not send more beats than a line holds
    no_extra_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        beat_valid_i |-> armed_q);

endmodule

// ==== hw/line_store.sv ====
// Tag, valid and data arrays for 16 direct-mapped lines.
// One-cycle read latency; writes are one word at a time under byte enables.
// Only the valid bits are cleared by reset.
`timescale 1ns/1ps

module line_store import dcache_cfg_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    array_port_if.array arr
);

    localparam int unsigned NumLines = 2 ** INDEX_W;

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------
    word_t data_q  [NumLines][BEATS_PER_LINE];
    tag_t  tag_q   [NumLines];
    logic  [NumLines-1:0] valid_q;

    // read-side registers
    line_t rd_line_q;
    tag_t  rd_tag_q;
    logic  rd_valid_q;

    // valid bits, set by a tag write only
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (arr.tag_wr_en) valid_q[arr.wr_index] <= 1'b1;
            if (arr.rd_en)     rd_valid_q <= valid_q[arr.rd_index];
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr.tag_wr_en) tag_q[arr.wr_index] <= arr.lookup_tag;
        // byte-lane write into one word of the line
        if (arr.wr_en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (arr.wr_be[b]) begin
                    data_q[arr.wr_index][arr.wr_word][b*8 +: 8] <= arr.wr_data[b*8 +: 8];
                end
            end
        end
        if (arr.rd_en) begin
            rd_tag_q <= tag_q[arr.rd_index];
            for (int w = 0; w < BEATS_PER_LINE; w++) begin
                rd_line_q[w*DATA_W +: DATA_W] <= data_q[arr.rd_index][w];
            end
        end
    end

    assign arr.rd_line = rd_line_q;
    // compare is done after the read, against the tag the FSM holds
    assign arr.hit     = rd_valid_q && (rd_tag_q == arr.lookup_tag);

    // controller never reads a line it is writing in the same cycle
    no_rd_wr_clash: assert property (@(posedge clk_i) disable iff (!rst_ni)
        arr.rd_en && (arr.wr_en || arr.tag_wr_en) |-> arr.rd_index != arr.wr_index);

endmodule

// ==== hw/dcache_fsm.sv ====
// Cache controller FSM. One request in flight, except a load hit may
// overlap with the next accepted request. Write-through, no allocate on
// store. Memory addresses are word aligned, byte lanes come from mem_be_o.
`timescale 1ns/1ps

module dcache_fsm import dcache_cfg_pkg::*; import dcache_ctrl_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // core port
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_we_i,
    input  logic [BE_W-1:0]   req_be_i,
    input  word_t             req_wdata_i,
    input  logic              bypass_i,
    output logic              resp_valid_o,
    output word_t             resp_rdata_o,
    // memory port
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output mem_cmd_e          mem_cmd_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [BE_W-1:0]   mem_be_o,
    output word_t             mem_wdata_o,
    input  logic              mem_rvalid_i,
    input  word_t             mem_rdata_i,
    // line store
    array_port_if.ctrl        arr,
    // refill beat counter
    output logic              cnt_start_o,
    output logic              cnt_beat_valid_o,
    output beat_idx_t         cnt_want_word_o,
    input  beat_idx_t         cnt_beat_idx_i,
    input  logic              cnt_is_wanted_i,
    input  logic              cnt_last_i
);

    ctrl_state_e state_d, state_q;

    // saved request
    index_t          index_q;
    tag_t            tag_q;
    beat_idx_t       word_q;
    logic [BE_W-1:0] be_q;
    logic            we_q;
    word_t           wdata_q;
    logic            bypass_q;
    // store hit, taken from the lookup cycle
    logic            hit_q;

    logic accept;

    // ready in IDLE, and in LOOKUP only when a load hit finishes there
    assign req_ready_o = (state_q == IDLE) ||
                         (state_q == LOOKUP && !we_q && !bypass_q && arr.hit);
    assign accept = req_valid_i && req_ready_o;

    assign cnt_want_word_o = word_q;

    // ----------------------------------------------------------
    // next state and outputs
    // ----------------------------------------------------------
    always_comb begin
        state_d          = state_q;
        resp_valid_o     = 1'b0;
        resp_rdata_o     = '0;
        mem_req_valid_o  = 1'b0;
        mem_cmd_o        = CMD_READ_WORD;
        mem_addr_o       = {tag_q, index_q, word_q, {(OFFSET_W-1){1'b0}}};
        mem_be_o         = be_q;
        mem_wdata_o      = wdata_q;
        cnt_start_o      = 1'b0;
        cnt_beat_valid_o = 1'b0;
        // array defaults, the read index follows the core address
        arr.rd_en        = 1'b0;
        arr.rd_index     = req_addr_i[OFFSET_W +: INDEX_W];
        arr.wr_en        = 1'b0;
        arr.wr_index     = index_q;
        arr.wr_word      = word_q;
        arr.wr_be        = be_q;
        arr.wr_data      = wdata_q;
        arr.tag_wr_en    = 1'b0;
        arr.lookup_tag   = tag_q;

        case (state_q)
            IDLE: ;
            LOOKUP: begin
                if (we_q) begin
                    state_d = STORE_WRITE;
                end else if (bypass_q) begin
                    state_d = BYPASS_REQ;
                end else if (arr.hit) begin
                    resp_valid_o = 1'b1;
                    resp_rdata_o = arr.rd_line[word_q*DATA_W +: DATA_W];
                    state_d      = IDLE;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            STORE_WRITE: begin
                // update the cached copy, memory gets the same word
                arr.wr_en       = hit_q;
                mem_req_valid_o = 1'b1;
                mem_cmd_o       = CMD_WRITE_WORD;
                if (mem_req_ready_i) state_d = IDLE;
            end
            REFILL_REQ: begin
                mem_req_valid_o = 1'b1;
                mem_cmd_o       = CMD_READ_LINE;
                mem_addr_o      = {tag_q, index_q, {OFFSET_W{1'b0}}};
                mem_be_o        = '1;
                if (mem_req_ready_i) begin
                    cnt_start_o = 1'b1;
                    state_d     = REFILL_DATA;
                end
            end
            REFILL_DATA: begin
                cnt_beat_valid_o = mem_rvalid_i;
                // every beat lands in the line
                arr.wr_en        = mem_rvalid_i;
                arr.wr_word      = cnt_beat_idx_i;
                arr.wr_be        = '1;
                arr.wr_data      = mem_rdata_i;
                // answer the core as soon as its own word shows up
                if (mem_rvalid_i && cnt_is_wanted_i) begin
                    resp_valid_o = 1'b1;
                    resp_rdata_o = mem_rdata_i;
                end
                // tag goes in with the final beat
                if (mem_rvalid_i && cnt_last_i) begin
                    arr.tag_wr_en = 1'b1;
                    state_d       = IDLE;
                end
            end
            BYPASS_REQ: begin
                mem_req_valid_o = 1'b1;
                mem_cmd_o       = CMD_READ_WORD;
                if (mem_req_ready_i) state_d = BYPASS_DATA;
            end
            BYPASS_DATA: begin
                if (mem_rvalid_i) begin
                    resp_valid_o = 1'b1;
                    resp_rdata_o = mem_rdata_i;
                    state_d      = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase

        // a new request always starts with a speculative line read
        if (accept) begin
            arr.rd_en = 1'b1;
            state_d   = LOOKUP;
        end
    end

    // ----------------------------------------------------------
    // registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            index_q  <= req_addr_i[OFFSET_W +: INDEX_W];
            tag_q    <= req_addr_i[ADDR_W-1 -: TAG_W];
            word_q   <= req_addr_i[OFFSET_W-1];
            be_q     <= req_be_i;
            we_q     <= req_we_i;
            wdata_q  <= req_wdata_i;
            // uncacheable region goes the bypass way too
            bypass_q <= bypass_i || (req_addr_i < CACHE_START_ADDR);
        end
        if (state_q == LOOKUP) hit_q <= arr.hit;
    end

    // command held steady until the memory takes it
    mem_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_cmd_o) &&
        $stable(mem_addr_o) && $stable(mem_be_o) && $stable(mem_wdata_o));

    // a store finishes without ever answering the core
    no_store_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept && req_we_i |=> (!resp_valid_o until_with (state_q == IDLE)));

endmodule

// ==== hw/dcache_lite.sv ====
// Direct-mapped, write-through data cache with a core port and one
// memory port. Loads only get responses and the core must always take them.
// Addresses below CACHE_START_ADDR are never cached.
`timescale 1ns/1ps

module dcache_lite import dcache_cfg_pkg::*; import dcache_ctrl_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    // core side
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_we_i,
    input  logic [BE_W-1:0]   req_be_i,
    input  word_t             req_wdata_i,
    input  logic              bypass_i,
    output logic              resp_valid_o,
    output word_t             resp_rdata_o,
    // memory side
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output mem_cmd_e          mem_cmd_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [BE_W-1:0]   mem_be_o,
    output word_t             mem_wdata_o,
    input  logic              mem_rvalid_i,
    input  word_t             mem_rdata_i
);

    array_port_if arr_if ();

    // counter handshake
    logic      cnt_start, cnt_beat_valid, cnt_is_wanted, cnt_last;
    beat_idx_t cnt_want_word, cnt_beat_idx;

    dcache_fsm fsm_i (
        .clk_i, .rst_ni,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_we_i, .req_be_i, .req_wdata_i,
        .bypass_i, .resp_valid_o, .resp_rdata_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_cmd_o, .mem_addr_o, .mem_be_o,
        .mem_wdata_o, .mem_rvalid_i, .mem_rdata_i,
        .arr              (arr_if.ctrl),
        .cnt_start_o      (cnt_start),
        .cnt_beat_valid_o (cnt_beat_valid),
        .cnt_want_word_o  (cnt_want_word),
        .cnt_beat_idx_i   (cnt_beat_idx),
        .cnt_is_wanted_i  (cnt_is_wanted),
        .cnt_last_i       (cnt_last)
    );

    refill_beat_counter cnt_i (
        .clk_i, .rst_ni,
        .start_i      (cnt_start),
        .beat_valid_i (cnt_beat_valid),
        .want_word_i  (cnt_want_word),
        .beat_idx_o   (cnt_beat_idx),
        .is_wanted_o  (cnt_is_wanted),
        .last_o       (cnt_last)
    );

    line_store store_i (
        .clk_i, .rst_ni,
        .arr (arr_if.array)
    );

endmodule

// ==== bench/mem_model.sv ====
// Backing memory behind the cache memory port.
// Unwritten words read as a pattern of their own address.
// Ready and rvalid stall at random, outputs change 2 ns after the clock edge.
`timescale 1ns/1ps

module mem_model import dcache_cfg_pkg::*; import dcache_ctrl_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  mem_cmd_e          cmd_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [BE_W-1:0]   be_i,
    input  word_t             wdata_i,
    output logic              rvalid_o,
    output word_t             rdata_o
);

    // written words, keyed by word-aligned byte address
    word_t  mem [logic [ADDR_W-1:0]];
    // read beats waiting to go out
    word_t  beat_q [$];
    integer seed = 23;

    function automatic word_t read_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] wa;
        wa = {addr[ADDR_W-1:3], 3'b000};
        if (mem.exists(wa)) return mem[wa];
        return {wa ^ 32'h5a5a_a5a5, ~wa};
    endfunction

    initial begin
        req_ready_o = 1'b0;
        rvalid_o    = 1'b0;
        rdata_o     = '0;
    end

    always @(posedge clk_i) begin
        word_t merged;
        // take the command that handshakes on this edge
        if (rst_ni && req_valid_i && req_ready_o) begin
            case (cmd_i)
                CMD_WRITE_WORD: begin
                    merged = read_word(addr_i);
                    for (int b = 0; b < BE_W; b++) begin
                        if (be_i[b]) merged[b*8 +: 8] = wdata_i[b*8 +: 8];
                    end
                    mem[{addr_i[ADDR_W-1:3], 3'b000}] = merged;
                end
                CMD_READ_WORD: beat_q.push_back(read_word(addr_i));
                // line read, word 0 first
                default: begin
                    for (int w = 0; w < BEATS_PER_LINE; w++) begin
                        beat_q.push_back(read_word(addr_i + w * 8));
                    end
                end
            endcase
        end
        #2;
        req_ready_o = rst_ni && (($random(seed) & 3) != 0);
        if (rst_ni && beat_q.size() > 0 && (($random(seed) & 3) != 0)) begin
            rvalid_o = 1'b1;
            rdata_o  = beat_q.pop_front();
        end else begin
            rvalid_o = 1'b0;
            rdata_o  = '0;
        end
    end

endmodule

// ==== bench/dcache_lite_tb.sv ====
// Testbench for dcache_lite against mem_model.
// Expected results come from a local model of memory words and cached lines.
// Requests go in one at a time, a load hit may overlap the next request.
`timescale 1ns/1ps

module dcache_lite_tb
    import dcache_cfg_pkg::*;
    import dcache_ctrl_pkg::*;
();

    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned N_DIRECTED   = 16;
    localparam int unsigned N_RAND       = 48;
    // 40 cycles per request is far above a stalled refill
    localparam int unsigned CYCLE_LIMIT  = RESET_CYCLES + 40 * (N_DIRECTED + N_RAND);

    logic              clk_i, rst_ni;
    logic              req_valid_i, req_ready_o, req_we_i, bypass_i;
    logic [ADDR_W-1:0] req_addr_i, mem_addr_o;
    logic [BE_W-1:0]   req_be_i, mem_be_o;
    word_t             req_wdata_i, resp_rdata_o, mem_wdata_o, mem_rdata_i;
    logic              resp_valid_o, mem_req_valid_o, mem_req_ready_i, mem_rvalid_i;
    mem_cmd_e          mem_cmd_o;

    integer seed = 23;
    int     err_cnt = 0;
    int     resp_cnt = 0;
    int     cycle_cnt = 0;

    dcache_lite dcache_lite_i (
        .clk_i, .rst_ni,
        .req_valid_i, .req_ready_o, .req_addr_i, .req_we_i, .req_be_i, .req_wdata_i,
        .bypass_i, .resp_valid_o, .resp_rdata_o,
        .mem_req_valid_o, .mem_req_ready_i, .mem_cmd_o, .mem_addr_o, .mem_be_o,
        .mem_wdata_o, .mem_rvalid_i, .mem_rdata_i
    );

    mem_model mem_model_i (
        .clk_i, .rst_ni,
        .req_valid_i (mem_req_valid_o),
        .req_ready_o (mem_req_ready_i),
        .cmd_i       (mem_cmd_o),
        .addr_i      (mem_addr_o),
        .be_i        (mem_be_o),
        .wdata_i     (mem_wdata_o),
        .rvalid_o    (mem_rvalid_i),
        .rdata_o     (mem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    word_t                 ref_mem [logic [ADDR_W-1:0]];
    logic [2**INDEX_W-1:0] ref_valid;
    tag_t                  ref_tag [2**INDEX_W];
    // what the next response and memory command must carry
    word_t                 exp_word;
    logic                  load_pending, exp_mem;
    mem_cmd_e              exp_cmd;
    logic [ADDR_W-1:0]     exp_addr;
    logic [BE_W-1:0]       exp_be;
    word_t                 exp_wdata;

    logic   accept, cacheable, hit_acc;
    index_t acc_index;
    tag_t   acc_tag;

    assign accept    = req_valid_i && req_ready_o;
    assign acc_index = req_addr_i[OFFSET_W +: INDEX_W];
    assign acc_tag   = req_addr_i[ADDR_W-1 -: TAG_W];
    assign cacheable = !bypass_i && (req_addr_i >= CACHE_START_ADDR);
    assign hit_acc   = accept && !req_we_i && cacheable &&
                       ref_valid[acc_index] && (ref_tag[acc_index] == acc_tag);

    function automatic word_t ref_read(input logic [ADDR_W-1:0] wa);
        if (ref_mem.exists(wa)) return ref_mem[wa];
        return {wa ^ 32'h5a5a_a5a5, ~wa};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata,
                                          input logic [BE_W-1:0] be);
        word_t res;
        res = old;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin
        logic [ADDR_W-1:0] wa;
        wa = {req_addr_i[ADDR_W-1:3], 3'b000};
        if (!rst_ni) begin
            ref_valid    <= '0;
            load_pending <= 1'b0;
            exp_mem      <= 1'b0;
        end else begin
            if (resp_valid_o) begin
                load_pending <= 1'b0;
                resp_cnt++;
            end
            if (mem_req_valid_o && mem_req_ready_i) exp_mem <= 1'b0;
            if (accept) begin
                // a hit is the only request that leaves memory alone
                exp_mem   <= !hit_acc;
                exp_addr  <= wa;
                exp_be    <= req_be_i;
                exp_wdata <= req_wdata_i;
                if (req_we_i) begin
                    exp_cmd     <= CMD_WRITE_WORD;
                    ref_mem[wa]  = merge_bytes(ref_read(wa), req_wdata_i, req_be_i);
                end else begin
                    load_pending <= 1'b1;
                    exp_word     <= ref_read(wa);
                    if (!cacheable) begin
                        exp_cmd <= CMD_READ_WORD;
                    end else begin
                        // miss or hit, the line is resident afterwards
                        exp_cmd              <= CMD_READ_LINE;
                        exp_addr             <= {wa[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                        ref_valid[acc_index] <= 1'b1;
                        ref_tag[acc_index]   <= acc_tag;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    reset_idle: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> req_ready_o && !resp_valid_o && !mem_req_valid_o)
        else begin
            err_cnt++;
            $display("ERR req_ready_o,resp_valid_o,mem_req_valid_o exp %h got %h", 3'b100,
                     $sampled({req_ready_o, resp_valid_o, mem_req_valid_o}));
        end

    resp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o |-> resp_rdata_o == exp_word)
        else begin
            err_cnt++;
            $display("ERR resp_rdata_o exp %h got %h", $sampled(exp_word),
                     $sampled(resp_rdata_o));
        end

    resp_for_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o |-> load_pending)
        else begin
            err_cnt++;
            $display("response raised with no load outstanding");
        end

    // each load is answered before the core moves on
    resp_not_lost: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept |-> !load_pending || resp_valid_o)
        else begin
            err_cnt++;
            $display("new request accepted while a load is still unanswered");
        end

    // misses, bypass loads and stores reach memory before anything moves on
    mem_issued_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (accept || resp_valid_o) |-> !exp_mem)
        else begin
            err_cnt++;
            $display("request accepted or load answered while a memory command was due");
        end

    hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hit_acc |=> resp_valid_o)
        else begin
            err_cnt++;
            $display("load hit not answered in the cycle after acceptance");
        end

    mem_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> exp_mem)
        else begin
            err_cnt++;
            $display("memory request raised where none was due");
        end

    mem_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_ready_i |-> mem_cmd_o == exp_cmd)
        else begin
            err_cnt++;
            $display("ERR mem_cmd_o exp %h got %h", $sampled(exp_cmd), $sampled(mem_cmd_o));
        end

    mem_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_ready_i |-> mem_addr_o == exp_addr)
        else begin
            err_cnt++;
            $display("ERR mem_addr_o exp %h got %h", $sampled(exp_addr), $sampled(mem_addr_o));
        end

    mem_store: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && mem_req_ready_i && exp_cmd == CMD_WRITE_WORD |->
        mem_be_o == exp_be && mem_wdata_o == exp_wdata)
        else begin
            err_cnt++;
            $display("ERR mem_be_o,mem_wdata_o exp %h %h got %h %h", $sampled(exp_be),
                     $sampled(exp_wdata), $sampled(mem_be_o), $sampled(mem_wdata_o));
        end

    mem_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_cmd_o) &&
        $stable(mem_addr_o) && $stable(mem_be_o) && $stable(mem_wdata_o))
        else begin
            err_cnt++;
            $display("memory command dropped or changed while memory was not ready");
        end

    core_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> !req_ready_o)
        else begin
            err_cnt++;
            $display("core port ready while a memory request is pending");
        end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    // holds the request until a mid-cycle look at req_ready_o sees it taken
    task automatic issue_request(input logic [ADDR_W-1:0] addr, input logic we,
                                 input logic [BE_W-1:0] be, input word_t wdata,
                                 input logic byp);
        logic taken;
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        req_we_i    = we;
        req_be_i    = be;
        req_wdata_i = wdata;
        bypass_i    = byp;
        do begin
            @(negedge clk_i);
            taken = req_ready_o;
            @(posedge clk_i);
        end while (!taken);
        #2;
        req_valid_i = 1'b0;
    endtask

    task automatic load_word(input logic [ADDR_W-1:0] addr, input logic byp);
        issue_request(addr, 1'b0, '0, '0, byp);
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                              input word_t wdata);
        issue_request(addr, 1'b1, be, wdata, 1'b0);
    endtask

    // word-aligned address, small pool so lines collide and repeat
    function automatic logic [ADDR_W-1:0] rand_addr(input logic cached);
        logic [ADDR_W-1:0] a;
        a = $random(seed) & 32'h0000_07f8;
        return cached ? (CACHE_START_ADDR | a) : a;
    endfunction

    initial begin
        logic [ADDR_W-1:0] a, b, c, u;
        int op;
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_we_i    = 1'b0;
        req_be_i    = '0;
        req_wdata_i = '0;
        bypass_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        a = rand_addr(1'b1) & 32'hffff_fff0;
        b = a ^ 32'h10;
        c = a ^ 32'h20;
        u = rand_addr(1'b0);
        // miss, then hits, then back-to-back hits
        load_word(a, 1'b0);
        load_word(a, 1'b0);
        load_word(a | 32'h8, 1'b0);
        load_word(a, 1'b0);
        load_word(a | 32'h8, 1'b0);
        load_word(a, 1'b0);
        // store into a cached line and into an absent one
        store_word(a, 8'h3c, {$random(seed), $random(seed)});
        load_word(a, 1'b0);
        store_word(b, 8'hc1, {$random(seed), $random(seed)});
        load_word(b, 1'b0);
        // bypass must not allocate
        load_word(c, 1'b1);
        load_word(c, 1'b0);
        // uncacheable region
        load_word(u, 1'b0);
        store_word(u, 8'h0f, {$random(seed), $random(seed)});
        load_word(u, 1'b0);
        load_word(c | 32'h8, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            op = $random(seed) & 7;
            a  = rand_addr(op != 7);
            if (op < 3) store_word(a, BE_W'($random(seed)), {$random(seed), $random(seed)});
            else load_word(a, op == 6);
        end

        // drain the last request
        while (load_pending || exp_mem || !req_ready_o) begin
            @(posedge clk_i);
            #2;
        end
        repeat (4) @(posedge clk_i);
        $display("summary: %0d requests, %0d load responses, %0d errors",
                 N_DIRECTED + N_RAND, resp_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("summary: %0d requests, %0d load responses, %0d errors",
                 N_DIRECTED + N_RAND, resp_cnt, err_cnt);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== dcache_lite.f ====
hw/dcache_cfg_pkg.sv
hw/dcache_ctrl_pkg.sv
hw/array_port_if.sv
hw/refill_beat_counter.sv
hw/line_store.sv
hw/dcache_fsm.sv
hw/dcache_lite.sv
bench/mem_model.sv
bench/dcache_lite_tb.sv

// ==== Bender.yml ====
package:
  name: dcache_lite

sources:
  - files:
      - hw/dcache_cfg_pkg.sv
      - hw/dcache_ctrl_pkg.sv
      - hw/array_port_if.sv
      - hw/refill_beat_counter.sv
      - hw/line_store.sv
      - hw/dcache_fsm.sv
      - hw/dcache_lite.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/dcache_lite_tb.sv
